// File: seq_params.svh
`ifndef SEQ_PARAMS_SVH
`define SEQ_PARAMS_SVH

// word widths
`define SEQ_CMD_WIDTH      32
`define SEQ_DATA_WIDTH     32
`define SEQ_REG_NUM_WIDTH  4
`define SEQ_FLAG_WIDTH     2

// register number of the instruction pointer
`define SEQ_REG_IP         15

// operand register numbers
`define SEQ_S1_NUM_LSB     0
`define SEQ_S0_NUM_LSB     4
`define SEQ_D_NUM_LSB      8
`define SEQ_CND_NUM_LSB    12

// pointer bits, one per operand
`define SEQ_S1_PTR_BIT     16
`define SEQ_S0_PTR_BIT     17
`define SEQ_D_PTR_BIT      18
`define SEQ_CND_PTR_BIT    19

// flag pairs
`define SEQ_S1_FLAGS_LSB   20
`define SEQ_S0_FLAGS_LSB   22
`define SEQ_D_FLAGS_LSB    24
`define SEQ_CND_FLAGS_LSB  26

`endif

// File: seqPkg.sv
`include "seq_params.svh"

package seqPkg;

  // raw command and condition data
  typedef logic [`SEQ_CMD_WIDTH-1:0] cmdWord;
  typedef logic [`SEQ_DATA_WIDTH-1:0] condWord;

  // per-operand fields
  typedef logic [`SEQ_REG_NUM_WIDTH-1:0] regNum;
  // 11 absent, 01/10 written back, 00 read only
  typedef logic [`SEQ_FLAG_WIDTH-1:0] opFlags;

  // order matters, the default transition steps to the next value
  typedef enum logic [4:0] {
    waitForStart,
    startBegin,
    readMemSize,
    afterMemSizeRead,
    startReadCmd,
    startReadCmdP,
    preexecute,
    writeRegIp,
    readCond,
    fillCond,
    readCondP,
    readSrc1,
    fillSrc1,
    readSrc1P,
    readSrc0,
    fillSrc0,
    readSrc0P,
    readDst,
    fillDstP,
    aluBegin,
    aluResults,
    writePrep,
    writeDst,
    writeDstP,
    writeCond,
    writeSrc1,
    writeSrc0,
    finishBegin,
    finishEnd
  } seqState;

endpackage

// File: cmdDecoder.sv
`include "seq_params.svh"

module cmdDecoder (
  input  seqPkg::cmdWord  command,
  input  seqPkg::condWord cond,
  output seqPkg::regNum   cndNum,
  output seqPkg::regNum   s1Num,
  output seqPkg::regNum   s0Num,
  output seqPkg::regNum   dNum,
  output logic            cndPtr,
  output logic            s1Ptr,
  output logic            s0Ptr,
  output logic            dPtr,
  output seqPkg::opFlags  cndFlags,
  output seqPkg::opFlags  s1Flags,
  output seqPkg::opFlags  s0Flags,
  output seqPkg::opFlags  dFlags,
  output logic            condTrue,
  output logic            ipSaveAllowed,
  output logic            dSaveAllowed,
  output logic            dSavePtrAllowed,
  output logic            cndSaveAllowed,
  output logic            s1SaveAllowed,
  output logic            s0SaveAllowed
);

  // write-back markers, flags differ
  logic cndWb;
  logic s1Wb;
  logic s0Wb;

  // field split
  assign cndNum = command[`SEQ_CND_NUM_LSB +: `SEQ_REG_NUM_WIDTH];
  assign s1Num  = command[`SEQ_S1_NUM_LSB +: `SEQ_REG_NUM_WIDTH];
  assign s0Num  = command[`SEQ_S0_NUM_LSB +: `SEQ_REG_NUM_WIDTH];
  assign dNum   = command[`SEQ_D_NUM_LSB +: `SEQ_REG_NUM_WIDTH];

  assign cndPtr = command[`SEQ_CND_PTR_BIT];
  assign s1Ptr  = command[`SEQ_S1_PTR_BIT];
  assign s0Ptr  = command[`SEQ_S0_PTR_BIT];
  assign dPtr   = command[`SEQ_D_PTR_BIT];

  assign cndFlags = command[`SEQ_CND_FLAGS_LSB +: `SEQ_FLAG_WIDTH];
  assign s1Flags  = command[`SEQ_S1_FLAGS_LSB +: `SEQ_FLAG_WIDTH];
  assign s0Flags  = command[`SEQ_S0_FLAGS_LSB +: `SEQ_FLAG_WIDTH];
  assign dFlags   = command[`SEQ_D_FLAGS_LSB +: `SEQ_FLAG_WIDTH];

  assign cndWb = ^cndFlags;
  assign s1Wb  = ^s1Flags;
  assign s0Wb  = ^s0Flags;

  // absent cond counts as always true
  assign condTrue = (&cndFlags) || (cond != '0);

  // dst only commits when the condition holds
  assign dSaveAllowed    = ~(&dFlags) && condTrue;
  // pointer-only dst, no register write of its own
  assign dSavePtrAllowed = (&dFlags) && dPtr && condTrue;

  // a later writer to the same register wins, dst is latest
  assign cndSaveAllowed = cndWb
                          && (dNum != cndNum || !dSaveAllowed)
                          && (s1Num != cndNum || !s1Wb)
                          && (s0Num != cndNum || !s0Wb);
  assign s1SaveAllowed  = s1Wb
                          && (dNum != s1Num || !dSaveAllowed)
                          && (s0Num != s1Num || !s0Wb);
  assign s0SaveAllowed  = s0Wb
                          && (dNum != s0Num || !dSaveAllowed);

  // ip save is blocked by any write aimed at the instruction pointer
  assign ipSaveAllowed = !((dSaveAllowed && dNum == `SEQ_REG_IP)
                           || (cndWb && cndNum == `SEQ_REG_IP)
                           || (s1Wb && s1Num == `SEQ_REG_IP)
                           || (s0Wb && s0Num == `SEQ_REG_IP));

endmodule

// File: fetchPlanner.sv
`include "seq_params.svh"

module fetchPlanner (
  input  seqPkg::regNum   cndNum,
  input  seqPkg::regNum   s1Num,
  input  seqPkg::regNum   s0Num,
  input  seqPkg::regNum   dNum,
  input  seqPkg::opFlags  cndFlags,
  input  seqPkg::opFlags  s1Flags,
  input  seqPkg::opFlags  s0Flags,
  input  logic            dPtr,
  input  logic            condRead,
  input  logic            src1Read,
  input  logic            src0Read,
  output seqPkg::seqState fetchAfterStart,
  output seqPkg::seqState fetchAfterCond,
  output seqPkg::seqState fetchAfterSrc1,
  output seqPkg::seqState fetchAfterSrc0
);
  import seqPkg::*;

  // operand present, so it has to be fetched
  logic cndUsed;
  logic s1Used;
  logic s0Used;

  // value already on hand, fill instead of read
  logic cndFill;
  logic s1Fill;
  logic s0Fill;
  logic dFill;

  assign cndUsed = ~(&cndFlags);
  assign s1Used  = ~(&s1Flags);
  assign s0Used  = ~(&s0Flags);

  // ip comes from the sequencer itself
  assign cndFill = (cndNum == `SEQ_REG_IP);

  // forwarding from earlier operands in fetch order
  assign s1Fill = (s1Num == `SEQ_REG_IP)
                  || (cndUsed && condRead && s1Num == cndNum);
  assign s0Fill = (s0Num == `SEQ_REG_IP)
                  || (cndUsed && condRead && s0Num == cndNum)
                  || (s1Used && src1Read && s0Num == s1Num);
  assign dFill  = (dNum == `SEQ_REG_IP)
                  || (cndUsed && condRead && dNum == cndNum)
                  || (s1Used && src1Read && dNum == s1Num)
                  || (s0Used && src0Read && dNum == s0Num);

  // priority chain built back to front
  always_comb begin
    if (dPtr) begin
      fetchAfterSrc0 = dFill ? fillDstP : readDst;
    end else begin
      fetchAfterSrc0 = aluBegin;
    end

    if (s0Used) begin
      fetchAfterSrc1 = s0Fill ? fillSrc0 : readSrc0;
    end else begin
      fetchAfterSrc1 = fetchAfterSrc0;
    end

    if (s1Used) begin
      fetchAfterCond = s1Fill ? fillSrc1 : readSrc1;
    end else begin
      fetchAfterCond = fetchAfterSrc1;
    end

    if (cndUsed) begin
      fetchAfterStart = cndFill ? fillCond : readCond;
    end else begin
      fetchAfterStart = fetchAfterCond;
    end
  end

endmodule

// File: sequencerFsm.sv
module sequencerFsm (
  input  logic            next_state,
  input  logic            rst,
  input  logic            threadEscape,
  input  logic            cndPtr,
  input  logic            s1Ptr,
  input  logic            s0Ptr,
  input  logic            dPtr,
  input  seqPkg::opFlags  dFlags,
  input  seqPkg::opFlags  cndFlags,
  input  logic            condTrue,
  input  logic            ipSaveAllowed,
  input  logic            dSaveAllowed,
  input  logic            dSavePtrAllowed,
  input  logic            cndSaveAllowed,
  input  logic            s1SaveAllowed,
  input  logic            s0SaveAllowed,
  input  seqPkg::seqState fetchAfterStart,
  input  seqPkg::seqState fetchAfterCond,
  input  seqPkg::seqState fetchAfterSrc1,
  input  seqPkg::seqState fetchAfterSrc0,
  output seqPkg::seqState state,
  output logic            nextStateDn
);
  import seqPkg::*;

  seqState stateNxt;
  // leaving the cond fetch, maybe via an ip save
  seqState condExit;
  // write-back chain, each entry skips to the next allowed writer
  seqState afterDstWrite;
  seqState afterCondWrite;
  seqState afterSrc1Write;

  // sticky within one instruction
  logic condDone;
  logic ipWritten;

  // false condition needs the ip saved once
  assign condExit = (ipSaveAllowed && !condTrue && !ipWritten) ? writeRegIp : fetchAfterCond;

  assign afterSrc1Write = s0SaveAllowed ? writeSrc0 : finishBegin;
  assign afterCondWrite = s1SaveAllowed ? writeSrc1 : afterSrc1Write;
  assign afterDstWrite  = cndSaveAllowed ? writeCond : afterCondWrite;

  always_comb begin
    case (state)
      preexecute: stateNxt = ipSaveAllowed ? fetchAfterStart : writeRegIp;
      // cond already fetched, or absent, resumes after cond
      writeRegIp: stateNxt = (condDone || &cndFlags) ? fetchAfterCond : fetchAfterStart;
      readCond, fillCond: stateNxt = cndPtr ? readCondP : condExit;
      readCondP: stateNxt = condExit;
      readSrc1, fillSrc1: stateNxt = s1Ptr ? readSrc1P : fetchAfterSrc1;
      readSrc1P: stateNxt = fetchAfterSrc1;
      readSrc0, fillSrc0: stateNxt = s0Ptr ? readSrc0P : fetchAfterSrc0;
      readSrc0P: stateNxt = fetchAfterSrc0;
      readDst, fillDstP: stateNxt = aluBegin;
      writePrep: begin
        if (dSaveAllowed) begin
          stateNxt = dPtr ? writeDstP : writeDst;
        end else if (dSavePtrAllowed) begin
          stateNxt = writeDstP;
        end else begin
          stateNxt = afterDstWrite;
        end
      end
      // register write follows the pointer write when dst is written back
      writeDstP: stateNxt = (^dFlags) ? writeDst : afterDstWrite;
      writeDst: stateNxt = afterDstWrite;
      writeCond: stateNxt = afterCondWrite;
      writeSrc1: stateNxt = afterSrc1Write;
      writeSrc0: stateNxt = finishBegin;
      finishEnd: stateNxt = waitForStart;
      default: stateNxt = seqState'(state + 5'd1);
    endcase

    // escape overrides the normal step
    if (threadEscape) begin
      case (state)
        waitForStart: stateNxt = waitForStart;
        finishBegin: stateNxt = finishEnd;
        finishEnd: stateNxt = waitForStart;
        default: stateNxt = finishBegin;
      endcase
    end
  end

  always_ff @(posedge next_state or posedge rst) begin
    if (rst) begin
      state       <= waitForStart;
      nextStateDn <= 1'b0;
      condDone    <= 1'b0;
      ipWritten   <= 1'b0;
    end else begin
      state       <= stateNxt;
      // ack level flips once per strobe
      nextStateDn <= ~nextStateDn;
      if (state == finishEnd) begin
        condDone  <= 1'b0;
        ipWritten <= 1'b0;
      end else begin
        if (state == readCond || state == fillCond) begin
          condDone <= 1'b1;
        end
        if (state == writeRegIp) begin
          ipWritten <= 1'b1;
        end
      end
    end
  end

endmodule

// File: instructionSequencer.sv
module instructionSequencer (
  input  logic            next_state,
  input  logic            rst,
  input  seqPkg::cmdWord  command,
  input  seqPkg::condWord cond,
  input  logic            threadEscape,
  input  logic            condRead,
  input  logic            src1Read,
  input  logic            src0Read,
  output seqPkg::seqState state,
  output logic            nextStateDn,
  output logic            ipSaveAllowed,
  output logic            dSaveAllowed,
  output logic            dSavePtrAllowed,
  output logic            cndSaveAllowed,
  output logic            s1SaveAllowed,
  output logic            s0SaveAllowed
);
  import seqPkg::*;

  // decoded fields
  regNum   cndNum;
  regNum   s1Num;
  regNum   s0Num;
  regNum   dNum;
  logic    cndPtr;
  logic    s1Ptr;
  logic    s0Ptr;
  logic    dPtr;
  opFlags  cndFlags;
  opFlags  s1Flags;
  opFlags  s0Flags;
  opFlags  dFlags;
  logic    condTrue;

  // fetch candidates
  seqState fetchAfterStart;
  seqState fetchAfterCond;
  seqState fetchAfterSrc1;
  seqState fetchAfterSrc0;

  cmdDecoder u_cmdDecoder (
    .command         (command),
    .cond            (cond),
    .cndNum          (cndNum),
    .s1Num           (s1Num),
    .s0Num           (s0Num),
    .dNum            (dNum),
    .cndPtr          (cndPtr),
    .s1Ptr           (s1Ptr),
    .s0Ptr           (s0Ptr),
    .dPtr            (dPtr),
    .cndFlags        (cndFlags),
    .s1Flags         (s1Flags),
    .s0Flags         (s0Flags),
    .dFlags          (dFlags),
    .condTrue        (condTrue),
    .ipSaveAllowed   (ipSaveAllowed),
    .dSaveAllowed    (dSaveAllowed),
    .dSavePtrAllowed (dSavePtrAllowed),
    .cndSaveAllowed  (cndSaveAllowed),
    .s1SaveAllowed   (s1SaveAllowed),
    .s0SaveAllowed   (s0SaveAllowed)
  );

  fetchPlanner u_fetchPlanner (
    .cndNum          (cndNum),
    .s1Num           (s1Num),
    .s0Num           (s0Num),
    .dNum            (dNum),
    .cndFlags        (cndFlags),
    .s1Flags         (s1Flags),
    .s0Flags         (s0Flags),
    .dPtr            (dPtr),
    .condRead        (condRead),
    .src1Read        (src1Read),
    .src0Read        (src0Read),
    .fetchAfterStart (fetchAfterStart),
    .fetchAfterCond  (fetchAfterCond),
    .fetchAfterSrc1  (fetchAfterSrc1),
    .fetchAfterSrc0  (fetchAfterSrc0)
  );

  sequencerFsm u_sequencerFsm (
    .next_state      (next_state),
    .rst             (rst),
    .threadEscape    (threadEscape),
    .cndPtr          (cndPtr),
    .s1Ptr           (s1Ptr),
    .s0Ptr           (s0Ptr),
    .dPtr            (dPtr),
    .dFlags          (dFlags),
    .cndFlags        (cndFlags),
    .condTrue        (condTrue),
    .ipSaveAllowed   (ipSaveAllowed),
    .dSaveAllowed    (dSaveAllowed),
    .dSavePtrAllowed (dSavePtrAllowed),
    .cndSaveAllowed  (cndSaveAllowed),
    .s1SaveAllowed   (s1SaveAllowed),
    .s0SaveAllowed   (s0SaveAllowed),
    .fetchAfterStart (fetchAfterStart),
    .fetchAfterCond  (fetchAfterCond),
    .fetchAfterSrc1  (fetchAfterSrc1),
    .fetchAfterSrc0  (fetchAfterSrc0),
    .state           (state),
    .nextStateDn     (nextStateDn)
  );

endmodule

// File: instructionSequencer_properties.sv
`include "seq_params.svh"

module instructionSequencerProperties (
  input logic            next_state,
  input logic            rst,
  input seqPkg::cmdWord  command,
  input seqPkg::condWord cond,
  input logic            threadEscape,
  input seqPkg::seqState state,
  input logic            nextStateDn,
  input logic            ipSaveAllowed,
  input logic            dSaveAllowed,
  input logic            dSavePtrAllowed,
  input logic            cndSaveAllowed,
  input logic            s1SaveAllowed,
  input logic            s0SaveAllowed
);
  timeunit 1ns;
  timeprecision 1ns;
  import seqPkg::*;

  // read by the testbench for its report
  int failCount = 0;

  // previous-strobe copies
  logic    rstQ = 1'b1;
  logic    dnQ = 1'b0;
  seqState expCondQ = waitForStart;
  // ip already saved in this instruction
  logic    ipSeen;

  logic    cndReadOp;
  logic    cndPtrBit;
  logic    dPtrBit;
  logic    noWriter;
  seqState expCondFetch;

  // fields taken straight from the command word
  regNum   cndN;
  regNum   s1N;
  regNum   s0N;
  regNum   dN;
  opFlags  cndF;
  opFlags  s1F;
  opFlags  s0F;
  opFlags  dF;
  // operand writes back, or dst commits
  logic    cndWr;
  logic    s1Wr;
  logic    s0Wr;
  logic    dWr;
  logic    condHolds;
  // ip, dst, dst pointer, cond, src1, src0
  logic [5:0] expSave;
  logic [5:0] gotSave;

  // flags 00 mean the cond operand is read
  assign cndReadOp = (command[`SEQ_CND_FLAGS_LSB +: `SEQ_FLAG_WIDTH] == 2'b00);
  assign cndPtrBit = command[`SEQ_CND_PTR_BIT];
  assign dPtrBit   = command[`SEQ_D_PTR_BIT];
  assign noWriter  = !dSaveAllowed && !dSavePtrAllowed && !cndSaveAllowed
                     && !s1SaveAllowed && !s0SaveAllowed;
  // ip as cond register is filled, not read
  assign expCondFetch = (command[`SEQ_CND_NUM_LSB +: `SEQ_REG_NUM_WIDTH] == `SEQ_REG_IP)
                        ? fillCond : readCond;

  assign cndN = command[`SEQ_CND_NUM_LSB +: `SEQ_REG_NUM_WIDTH];
  assign s1N  = command[`SEQ_S1_NUM_LSB +: `SEQ_REG_NUM_WIDTH];
  assign s0N  = command[`SEQ_S0_NUM_LSB +: `SEQ_REG_NUM_WIDTH];
  assign dN   = command[`SEQ_D_NUM_LSB +: `SEQ_REG_NUM_WIDTH];
  assign cndF = command[`SEQ_CND_FLAGS_LSB +: `SEQ_FLAG_WIDTH];
  assign s1F  = command[`SEQ_S1_FLAGS_LSB +: `SEQ_FLAG_WIDTH];
  assign s0F  = command[`SEQ_S0_FLAGS_LSB +: `SEQ_FLAG_WIDTH];
  assign dF   = command[`SEQ_D_FLAGS_LSB +: `SEQ_FLAG_WIDTH];

  // differing flags mark a write-back operand
  assign cndWr = (cndF == 2'b01 || cndF == 2'b10);
  assign s1Wr  = (s1F == 2'b01 || s1F == 2'b10);
  assign s0Wr  = (s0F == 2'b01 || s0F == 2'b10);
  // absent cond is always true
  assign condHolds = (cndF == 2'b11) || (cond != '0);
  assign dWr = (dF != 2'b11) && condHolds;

  // no write may land on the ip register
  assign expSave[5] = !((dWr && dN == `SEQ_REG_IP) || (cndWr && cndN == `SEQ_REG_IP)
                        || (s1Wr && s1N == `SEQ_REG_IP) || (s0Wr && s0N == `SEQ_REG_IP));
  assign expSave[4] = dWr;
  // pointer-only dst
  assign expSave[3] = (dF == 2'b11) && dPtrBit && condHolds;
  // later operand in cond, src1, src0, dst order wins a shared register
  assign expSave[2] = cndWr && !(s1Wr && s1N == cndN) && !(s0Wr && s0N == cndN)
                      && !(dWr && dN == cndN);
  assign expSave[1] = s1Wr && !(s0Wr && s0N == s1N) && !(dWr && dN == s1N);
  assign expSave[0] = s0Wr && !(dWr && dN == s0N);

  assign gotSave = {ipSaveAllowed, dSaveAllowed, dSavePtrAllowed, cndSaveAllowed,
                    s1SaveAllowed, s0SaveAllowed};

  always @(posedge next_state) begin
    rstQ     <= rst;
    dnQ      <= nextStateDn;
    expCondQ <= expCondFetch;
  end

  always_ff @(posedge next_state or posedge rst) begin
    if (rst) begin
      ipSeen <= 1'b0;
    end else if (state == finishEnd) begin
      ipSeen <= 1'b0;
    end else if (state == writeRegIp) begin
      ipSeen <= 1'b1;
    end
  end

  resetIdle: assert property (@(posedge next_state)
    rst |-> (state == waitForStart && nextStateDn == 1'b0))
    else begin
      $error("MISMATCH state 0x%0h nextStateDn 0x%0h, expected 0x0 0x0",
             $sampled(state), $sampled(nextStateDn));
      failCount++;
    end

  // ack level flips on every strobe out of reset
  ackToggle: assert property (@(posedge next_state)
    (!rst && !rstQ) |-> (nextStateDn == !dnQ))
    else begin
      $error("MISMATCH nextStateDn got 0x%0h expected 0x%0h", $sampled(nextStateDn),
             !$sampled(dnQ));
      failCount++;
    end

  // permissions depend on the command and cond only
  savePerms: assert property (@(posedge next_state)
    !rst |-> (gotSave == expSave))
    else begin
      $error("MISMATCH save permissions {ip,d,dPtr,cnd,s1,s0} got 0x%0h expected 0x%0h",
             $sampled(gotSave), $sampled(expSave));
      failCount++;
    end

  escapeAbort: assert property (@(posedge next_state)
    (!rst && threadEscape && state != waitForStart && state != finishBegin
     && state != finishEnd) |=> (state == finishBegin))
    else begin
      $error("MISMATCH state got 0x%0h expected 0x%0h", $sampled(state), finishBegin);
      failCount++;
    end

  escapeFinish: assert property (@(posedge next_state)
    (!rst && threadEscape && state == finishBegin) |=> (state == finishEnd))
    else begin
      $error("MISMATCH state got 0x%0h expected 0x%0h", $sampled(state), finishEnd);
      failCount++;
    end

  // cond is first in fetch order
  condFetch: assert property (@(posedge next_state)
    (!rst && !threadEscape && state == preexecute && ipSaveAllowed && cndReadOp)
    |=> (state == expCondQ))
    else begin
      $error("MISMATCH state got 0x%0h expected 0x%0h", $sampled(state),
             $sampled(expCondQ));
      failCount++;
    end

  condIpSave: assert property (@(posedge next_state)
    (!rst && !threadEscape && (state == readCond || state == fillCond) && !cndPtrBit
     && ipSaveAllowed && cond == '0 && !ipSeen) |=> (state == writeRegIp))
    else begin
      $error("MISMATCH state got 0x%0h expected 0x%0h", $sampled(state), writeRegIp);
      failCount++;
    end

  dstWrite: assert property (@(posedge next_state)
    (!rst && !threadEscape && state == writePrep && dSaveAllowed && !dPtrBit)
    |=> (state == writeDst))
    else begin
      $error("MISMATCH state got 0x%0h expected 0x%0h", $sampled(state), writeDst);
      failCount++;
    end

  noWriteBack: assert property (@(posedge next_state)
    (!rst && !threadEscape && state == writePrep && noWriter) |=> (state == finishBegin))
    else begin
      $error("MISMATCH state got 0x%0h expected 0x%0h", $sampled(state), finishBegin);
      failCount++;
    end

endmodule

// File: instructionSequencer_tb.sv
`include "seq_params.svh"

module instructionSequencer_tb;
  timeunit 1ns;
  timeprecision 1ns;
  import seqPkg::*;

  localparam int CLK_PERIOD = 100;
  localparam int NUM_DIRECTED = 6;
  localparam int NUM_RANDOM = 10;
  localparam int NUM_TESTS = NUM_DIRECTED + NUM_RANDOM;
  // longest instruction stays under 30 strobes
  localparam int CYCLES_PER_TEST = 40;

  logic    next_state;
  logic    rst;
  cmdWord  command;
  condWord cond;
  logic    threadEscape;
  logic    condRead;
  logic    src1Read;
  logic    src0Read;
  seqState state;
  logic    nextStateDn;
  logic    ipSaveAllowed;
  logic    dSaveAllowed;
  logic    dSavePtrAllowed;
  logic    cndSaveAllowed;
  logic    s1SaveAllowed;
  logic    s0SaveAllowed;

  logic [31:0] rngState;
  int          testsRun;
  int          testsFailed;
  int          failsBefore;

  instructionSequencer u_instructionSequencer (
    .next_state      (next_state),
    .rst             (rst),
    .command         (command),
    .cond            (cond),
    .threadEscape    (threadEscape),
    .condRead        (condRead),
    .src1Read        (src1Read),
    .src0Read        (src0Read),
    .state           (state),
    .nextStateDn     (nextStateDn),
    .ipSaveAllowed   (ipSaveAllowed),
    .dSaveAllowed    (dSaveAllowed),
    .dSavePtrAllowed (dSavePtrAllowed),
    .cndSaveAllowed  (cndSaveAllowed),
    .s1SaveAllowed   (s1SaveAllowed),
    .s0SaveAllowed   (s0SaveAllowed)
  );

  bind instructionSequencer instructionSequencerProperties u_props (
    .next_state      (next_state),
    .rst             (rst),
    .command         (command),
    .cond            (cond),
    .threadEscape    (threadEscape),
    .state           (state),
    .nextStateDn     (nextStateDn),
    .ipSaveAllowed   (ipSaveAllowed),
    .dSaveAllowed    (dSaveAllowed),
    .dSavePtrAllowed (dSavePtrAllowed),
    .cndSaveAllowed  (cndSaveAllowed),
    .s1SaveAllowed   (s1SaveAllowed),
    .s0SaveAllowed   (s0SaveAllowed)
  );

  initial begin
    next_state = 1'b0;
    forever #(CLK_PERIOD / 2) next_state = ~next_state;
  end

  // bound on total run time
  initial begin
    #(NUM_TESTS * CYCLES_PER_TEST * CLK_PERIOD);
    $display("watchdog expired during test %0d, sequence never reached finishEnd",
             testsRun + 1);
    $display("*** TEST FAILED ***");
    $finish;
  end

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  // ptrs ordered cnd, d, s0, s1
  function automatic cmdWord buildCommand(input opFlags cndF, input opFlags dF,
                                          input opFlags s0F, input opFlags s1F,
                                          input logic [3:0] ptrs,
                                          input regNum cndN, input regNum dN,
                                          input regNum s0N, input regNum s1N);
    cmdWord c;
    c = '0;
    c[`SEQ_CND_NUM_LSB +: `SEQ_REG_NUM_WIDTH] = cndN;
    c[`SEQ_D_NUM_LSB +: `SEQ_REG_NUM_WIDTH]   = dN;
    c[`SEQ_S0_NUM_LSB +: `SEQ_REG_NUM_WIDTH]  = s0N;
    c[`SEQ_S1_NUM_LSB +: `SEQ_REG_NUM_WIDTH]  = s1N;
    c[`SEQ_CND_PTR_BIT] = ptrs[3];
    c[`SEQ_D_PTR_BIT]   = ptrs[2];
    c[`SEQ_S0_PTR_BIT]  = ptrs[1];
    c[`SEQ_S1_PTR_BIT]  = ptrs[0];
    c[`SEQ_CND_FLAGS_LSB +: `SEQ_FLAG_WIDTH] = cndF;
    c[`SEQ_D_FLAGS_LSB +: `SEQ_FLAG_WIDTH]   = dF;
    c[`SEQ_S0_FLAGS_LSB +: `SEQ_FLAG_WIDTH]  = s0F;
    c[`SEQ_S1_FLAGS_LSB +: `SEQ_FLAG_WIDTH]  = s1F;
    return c;
  endfunction

  // hints ordered cond, src1, src0
  task automatic applyInstruction(input cmdWord cmd, input condWord cnd,
                                  input logic [2:0] hints);
    @(posedge next_state);
    command  <= cmd;
    cond     <= cnd;
    condRead <= hints[2];
    src1Read <= hints[1];
    src0Read <= hints[0];
  endtask

  // state sampled on the falling edge
  task automatic waitForState(input seqState target, output int cycles);
    cycles = 0;
    do begin
      @(negedge next_state);
      cycles++;
    end while (state != target);
  endtask

  task automatic reportTest(input string name, input int cycles);
    int fails;
    fails = u_instructionSequencer.u_props.failCount - failsBefore;
    failsBefore = u_instructionSequencer.u_props.failCount;
    testsRun++;
    if (fails != 0) begin
      testsFailed++;
    end
    $display("test %0d %s: %0d strobes, %0d assertion failures", testsRun, name, cycles,
             fails);
  endtask

  initial begin
    int      cycles;
    int      totalFails;
    cmdWord  rndCmd;
    condWord rndCond;
    rst          = 1'b1;
    command      = '0;
    cond         = '0;
    threadEscape = 1'b0;
    condRead     = 1'b0;
    src1Read     = 1'b0;
    src0Read     = 1'b0;
    rngState     = 32'd7;
    testsRun     = 0;
    testsFailed  = 0;
    failsBefore  = 0;

    repeat (2) @(posedge next_state);
    rst <= 1'b0;
    @(negedge next_state);
    reportTest("reset", 2);

    // cond register is the ip, dst written back
    applyInstruction(buildCommand(2'b00, 2'b01, 2'b00, 2'b00, 4'b0000,
                                  4'd15, 4'd3, 4'd2, 4'd1), 32'h5, 3'b000);
    waitForState(finishEnd, cycles);
    reportTest("condFill", cycles);

    applyInstruction(buildCommand(2'b00, 2'b01, 2'b00, 2'b00, 4'b0000,
                                  4'd4, 4'd3, 4'd2, 4'd1), 32'h1, 3'b100);
    waitForState(finishEnd, cycles);
    reportTest("condRead", cycles);

    // false cond, so ip save and no writer
    applyInstruction(buildCommand(2'b00, 2'b01, 2'b00, 2'b00, 4'b0000,
                                  4'd4, 4'd3, 4'd2, 4'd1), 32'h0, 3'b000);
    waitForState(finishEnd, cycles);
    reportTest("ipSave", cycles);

    // every operand through its pointer state
    applyInstruction(buildCommand(2'b00, 2'b10, 2'b00, 2'b00, 4'b1111,
                                  4'd5, 4'd8, 4'd7, 4'd6), 32'h1, 3'b111);
    waitForState(finishEnd, cycles);
    reportTest("ptrChain", cycles);

    // escape raised once the fetch starts
    applyInstruction(buildCommand(2'b00, 2'b01, 2'b00, 2'b00, 4'b0000,
                                  4'd4, 4'd3, 4'd2, 4'd1), 32'h3, 3'b000);
    waitForState(preexecute, cycles);
    @(posedge next_state);
    threadEscape <= 1'b1;
    waitForState(finishEnd, cycles);
    @(posedge next_state);
    threadEscape <= 1'b0;
    reportTest("escape", cycles);

    for (int i = 0; i < NUM_RANDOM; i++) begin
      rngState = xorshift32(rngState);
      rndCmd = rngState;
      rngState = xorshift32(rngState);
      // zero cond about half the time
      rndCond = rngState[31] ? 32'h0 : rngState;
      rngState = xorshift32(rngState);
      applyInstruction(rndCmd, rndCond, rngState[2:0]);
      waitForState(finishEnd, cycles);
      reportTest("random", cycles);
    end

    // let the last implications complete
    repeat (2) @(negedge next_state);
    totalFails = u_instructionSequencer.u_props.failCount;
    $display("tests run %0d, tests failed %0d, assertion failures %0d", testsRun,
             testsFailed, totalFails);
    if (testsFailed == 0 && totalFails == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

endmodule

// File: instructionSequencer.f
+incdir+.
seqPkg.sv
cmdDecoder.sv
fetchPlanner.sv
sequencerFsm.sv
instructionSequencer.sv
instructionSequencer_properties.sv
instructionSequencer_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Compile and run the instruction sequencer testbench with Verilator.
set -u
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
  --top-module instructionSequencer_tb \
  -f instructionSequencer.f \
  -o instructionSequencer_sim
if [ $? -ne 0 ]; then
  echo "compile failed"
  exit 1
fi

# assertion errors must not stop the run before the summary
output=$(./obj_dir/instructionSequencer_sim +verilator+error+limit+100000)
runStatus=$?
echo "$output"
if [ $runStatus -ne 0 ]; then
  echo "simulation exited with status $runStatus"
  exit 1
fi

if echo "$output" | grep -qF "*** TEST PASSED ***"; then
  exit 0
fi
exit 1
